// File: all.f
logic/agu_pkg.sv
logic/agu_cfg_if.sv
logic/agu_regs.sv
logic/agu_addr_gen.sv
logic/agu_scratchpad.sv
logic/agu_top.sv
testbench/agu_clk_gen.sv
testbench/agu_checker.sv
testbench/agu_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module agu_tb -f all.f -o agu_sim
./obj_dir/agu_sim +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -qx "Verification passed" sim.log; then
   echo "simulation result: pass"
else
   echo "simulation result: fail"
   exit 1
fi

// File: testbench/agu_tb.sv
`timescale 1ns/10ps

module agu_tb;

   import agu_pkg::*;

   // positions per case times four, then the delays, then the APB traffic.
   localparam int TOTAL_POSITIONS = 8 + 24 + 15 + 42 + 40;
   localparam int TOTAL_DELAY     = 0 + 20 + 3 + 5 + 2;
   localparam int APB_CYCLES      = 3 * (MEM_WORDS + 5 * 12 + 4);
   localparam int TIMEOUT_CYCLES  = 4 * TOTAL_POSITIONS + TOTAL_DELAY + APB_CYCLES + 16;

   logic               clk_i;
   logic               rst_i;
   logic               psel_i;
   logic               penable_i;
   logic               pwrite_i;
   logic [PADDR_W-1:0] paddr_i;
   logic [DATA_W-1:0]  pwdata_i;
   logic [DATA_W-1:0]  prdata_o;
   logic               pready_o;
   logic               pslverr_o;
   logic               dout_valid_o;
   logic               dout_ready_i;
   logic [DATA_W-1:0]  dout_data_o;
   logic               done_o;

   logic [DATA_W-1:0]  mem_model [MEM_WORDS];
   logic [DATA_W-1:0]  exp_q [$];
   integer             seed = 32'h25a2_37af;
   logic [31:0]        rnd;
   logic               bp_en;
   int                 cycle_cnt = 0;
   int                 err_cnt = 0;
   int                 beat_cnt = 0;
   int                 first_valid_cyc = -1;

   agu_clk_gen u_clk_gen (.clk_o(clk_i), .rst_o(rst_i));

   agu_top UUT (.*);

   bind agu_top agu_checker u_checker (
      .clk_i, .rst_i, .dout_valid_i(dout_valid_o), .dout_ready_i,
      .dout_data_i(dout_data_o), .pready_i(pready_o), .done_i(done_o), .run_i(cfg_if.run)
   );

   function automatic logic [DATA_W-1:0] fill_word(int idx);
      return (32'h9E37_79B9 * (idx + 1)) ^ idx;
   endfunction

   // iterations outside, positions inside, one word per in-window position.
   function automatic int expected_stream(int start, int duty, int period, int incr,
                                          int iter, int shift);
      int addr;
      int n_per;
      int n_iter;
      int it;
      int p;
      int n;
      addr   = start;
      n_per  = (period == 0) ? 1 : period;
      n_iter = (iter == 0) ? 1 : iter;
      n      = 0;
      for (it = 0; it < n_iter; it++) begin
         for (p = 0; p < n_per; p++) begin
            if (p < duty) begin
               exp_q.push_back(mem_model[(addr & ((1 << ADDR_W) - 1)) >> BYTE_OFS_W]);
               n++;
               if (p != n_per - 1) addr += incr * 4;
            end
         end
         if (it != n_iter - 1) addr += shift * 4;  // byte address wraps at ADDR_W.
      end
      return n;
   endfunction

   // the slave never stalls and never flags an error.
   task automatic check_slave_resp(input logic [PADDR_W-1:0] addr);
      if (pready_o !== 1'b1 || pslverr_o !== 1'b0) begin
         $display("FAILED t=%0t: access to %h ended with pready_o=%b pslverr_o=%b",
                  $time, addr, pready_o, pslverr_o);
         err_cnt++;
      end
   endtask

   task automatic apb_write(input logic [PADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
      @(posedge clk_i);
      psel_i    <= 1'b1;
      penable_i <= 1'b0;
      pwrite_i  <= 1'b1;
      paddr_i   <= addr;
      pwdata_i  <= data;
      @(posedge clk_i);
      penable_i <= 1'b1;
      @(posedge clk_i);
      check_slave_resp(addr);
      psel_i    <= 1'b0;
      penable_i <= 1'b0;
      pwrite_i  <= 1'b0;
   endtask

   task automatic apb_read(input logic [PADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
      @(posedge clk_i);
      psel_i    <= 1'b1;
      penable_i <= 1'b0;
      pwrite_i  <= 1'b0;
      paddr_i   <= addr;
      @(posedge clk_i);
      penable_i <= 1'b1;
      @(posedge clk_i);
      data = prdata_o;  // end of access phase.
      check_slave_resp(addr);
      psel_i    <= 1'b0;
      penable_i <= 1'b0;
   endtask

   task automatic expect_status(input logic [DATA_W-1:0] expected);
      logic [DATA_W-1:0] rd;
      apb_read(REG_STATUS, rd);
      if (rd !== expected) begin
         $display("FAILED t=%0t: REG_STATUS read %h, expected %h", $time, rd, expected);
         err_cnt++;
      end
   endtask

   task automatic run_case(input int start, duty, period, incr, iter, shift, delay,
                           input bit restart);
      int start_cyc;
      int n;
      apb_write(REG_START, start);
      apb_write(REG_DUTY, duty);
      apb_write(REG_PERIOD, period);
      apb_write(REG_INCR, incr);
      apb_write(REG_ITER, iter);
      apb_write(REG_SHIFT, shift);
      apb_write(REG_DELAY, delay);
      n = expected_stream(start, duty, period, incr, iter, shift);
      first_valid_cyc = -1;
      apb_write(REG_CTRL, 1);
      start_cyc = cycle_cnt;
      while (done_o) @(posedge clk_i);
      if (restart) apb_write(REG_CTRL, 1);  // ignored while busy.
      expect_status(0);
      while (!done_o) @(posedge clk_i);
      if (exp_q.size() != 0) begin
         $display("error: done_o rose with %0d of %0d beats still missing", exp_q.size(), n);
         err_cnt++;
      end
      // run pulse, generator load, scratchpad accept, then the sampling edge.
      if (first_valid_cyc - start_cyc != delay + 3) begin
         $display("FAILED t=%0t: first beat %0d cycles after start, expected %0d",
                  $time, first_valid_cyc - start_cyc, delay + 3);
         err_cnt++;
      end
      expect_status(1);
   endtask

   // ======================================================================
   // clocked processes
   // ======================================================================
   always @(posedge clk_i) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("Verification failed");
         $finish;
      end
   end

   always @(posedge clk_i) begin
      rnd = $random(seed);
      dout_ready_i <= bp_en ? (rnd[1:0] != 2'b00) : 1'b1;
   end

   // compare each accepted beat against the reference queue.
   always @(posedge clk_i) begin
      if (!rst_i) begin
         if (dout_valid_o && first_valid_cyc < 0) first_valid_cyc = cycle_cnt;
         if (dout_valid_o && dout_ready_i) begin
            if (exp_q.size() == 0) begin
               $display("FAILED t=%0t: unexpected beat %h", $time, dout_data_o);
               err_cnt++;
            end else if (dout_data_o !== exp_q[0]) begin
               $display("FAILED t=%0t: beat %0d is %h, expected %h",
                        $time, beat_cnt, dout_data_o, exp_q[0]);
               err_cnt++;
               void'(exp_q.pop_front());
            end else begin
               void'(exp_q.pop_front());
            end
            beat_cnt++;
         end
      end
   end

   // ======================================================================
   // stimulus
   // ======================================================================
   initial begin
      int i;
      psel_i       <= 1'b0;
      penable_i    <= 1'b0;
      pwrite_i     <= 1'b0;
      paddr_i      <= '0;
      pwdata_i     <= '0;
      dout_ready_i <= 1'b1;
      bp_en        <= 1'b0;
      @(negedge rst_i);
      @(posedge clk_i);
      if (done_o !== 1'b1 || dout_valid_o !== 1'b0) begin
         $display("FAILED t=%0t: after reset done_o=%b dout_valid_o=%b", $time, done_o,
                  dout_valid_o);
         err_cnt++;
      end
      expect_status(1);
      for (i = 0; i < MEM_WORDS; i++) begin
         mem_model[i] = fill_word(i);
         apb_write(MEM_BASE + PADDR_W'(i * 4), mem_model[i]);
      end
      run_case(32'h040, 1, 0, 0, 8, 1, 0, 0);     // contiguous.
      run_case(32'h100, 3, 6, 2, 4, 5, 20, 0);    // strided with delay.
      run_case(32'h014, 4, 5, -1, 3, -7, 3, 0);   // walks down and wraps.
      bp_en <= 1'b1;
      run_case(32'h200, 5, 7, 3, 6, -2, 5, 0);
      run_case(32'h080, 4, 4, 1, 10, 0, 2, 1);    // restart attempt while busy.
      repeat (8) @(posedge clk_i);
      $display("errors: %0d testbench, %0d assertion, %0d beats compared",
               err_cnt, UUT.u_checker.err_cnt, beat_cnt);
      if (err_cnt == 0 && UUT.u_checker.err_cnt == 0) begin
         $display("Verification passed");
      end else begin
         $display("Verification failed");
      end
      $finish;
   end

endmodule

// File: testbench/agu_checker.sv
`timescale 1ns/10ps

module agu_checker #(
   parameter int DATA_W = agu_pkg::DATA_W
) (
   input logic              clk_i,
   input logic              rst_i,
   input logic              dout_valid_i,
   input logic              dout_ready_i,
   input logic [DATA_W-1:0] dout_data_i,
   input logic              pready_i,
   input logic              done_i,
   input logic              run_i
);

   logic run_seen;
   int   err_cnt = 0;

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         run_seen <= 1'b0;
      end else if (run_i) begin
         run_seen <= 1'b1;
      end
   end

   // ======================================================================
   // output stream and bus rules
   // ======================================================================
   a_data_stable: assert property (@(posedge clk_i) disable iff (rst_i)
      dout_valid_i && !dout_ready_i |=> $stable(dout_data_i))
   else begin
      $error("dout_data_o changed while stalled");
      err_cnt++;
   end

   a_valid_held: assert property (@(posedge clk_i) disable iff (rst_i)
      dout_valid_i && !dout_ready_i |=> dout_valid_i)
   else begin
      $error("dout_valid_o dropped before it was taken");
      err_cnt++;
   end

   a_pready_high: assert property (@(posedge clk_i) disable iff (rst_i) pready_i)
   else begin
      $error("pready_o went low");
      err_cnt++;
   end

   a_done_idle: assert property (@(posedge clk_i) disable iff (rst_i) !run_seen |-> done_i)
   else begin
      $error("done_o low although no run has started");
      err_cnt++;
   end

endmodule

// File: testbench/agu_clk_gen.sv
`timescale 1ns/10ps

module agu_clk_gen #(
   parameter int PERIOD_NS  = 40,
   parameter int RST_CYCLES = 5
) (
   output logic clk_o,
   output logic rst_o
);

   always begin
      clk_o = 1'b0;
      #(PERIOD_NS / 2);
      clk_o = 1'b1;
      #(PERIOD_NS / 2);
   end

   initial begin
      rst_o = 1'b1;
      repeat (RST_CYCLES) @(posedge clk_o);
      rst_o <= 1'b0;  // released on a rising edge.
   end

endmodule

// File: logic/agu_top.sv
`timescale 1ns/10ps

module agu_top #(
   parameter int ADDR_W   = agu_pkg::ADDR_W,
   parameter int PERIOD_W = agu_pkg::PERIOD_W,
   parameter int DELAY_W  = agu_pkg::DELAY_W,
   parameter int DATA_W   = agu_pkg::DATA_W
) (
   input  logic                         clk_i,
   input  logic                         rst_i,
   input  logic                         psel_i,
   input  logic                         penable_i,
   input  logic                         pwrite_i,
   input  logic [agu_pkg::PADDR_W-1:0]  paddr_i,
   input  logic [DATA_W-1:0]            pwdata_i,
   output logic [DATA_W-1:0]            prdata_o,
   output logic                         pready_o,
   output logic                         pslverr_o,
   output logic                         dout_valid_o,
   input  logic                         dout_ready_i,
   output logic [DATA_W-1:0]            dout_data_o,
   output logic                         done_o
);

   logic               mem_we;
   logic [7:0]         mem_waddr;
   logic [DATA_W-1:0]  mem_wdata;
   logic               gen_valid;
   logic               gen_ready;
   logic [ADDR_W-1:0]  gen_addr;
   logic               gen_done;

   // complete only once the last word has left the output.
   assign done_o = gen_done && !dout_valid_o;

   agu_cfg_if #(.ADDR_W(ADDR_W), .PERIOD_W(PERIOD_W), .DELAY_W(DELAY_W)) cfg_if ();

   agu_regs #(.ADDR_W(ADDR_W), .PERIOD_W(PERIOD_W), .DELAY_W(DELAY_W), .DATA_W(DATA_W)) u_regs (
      .clk_i, .rst_i, .psel_i, .penable_i, .pwrite_i, .paddr_i, .pwdata_i,
      .prdata_o, .pready_o, .pslverr_o,
      .cfg(cfg_if.regs_mp), .done_i(done_o),
      .mem_we_o(mem_we), .mem_waddr_o(mem_waddr), .mem_wdata_o(mem_wdata)
   );

   agu_addr_gen #(.ADDR_W(ADDR_W), .PERIOD_W(PERIOD_W), .DELAY_W(DELAY_W)) u_addr_gen (
      .clk_i, .rst_i, .cfg(cfg_if.gen_mp),
      .valid_o(gen_valid), .ready_i(gen_ready), .addr_o(gen_addr), .done_o(gen_done)
   );

   agu_scratchpad #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) u_scratchpad (
      .clk_i, .rst_i, .we_i(mem_we), .waddr_i(mem_waddr), .wdata_i(mem_wdata),
      .addr_valid_i(gen_valid), .addr_ready_o(gen_ready), .addr_i(gen_addr),
      .dout_valid_o, .dout_ready_i, .dout_data_o
   );

endmodule

// File: logic/agu_scratchpad.sv
`timescale 1ns/10ps

module agu_scratchpad #(
   parameter int ADDR_W = agu_pkg::ADDR_W,
   parameter int DATA_W = agu_pkg::DATA_W
) (
   input  logic              clk_i,
   input  logic              rst_i,
   input  logic              we_i,
   input  logic [7:0]        waddr_i,
   input  logic [DATA_W-1:0] wdata_i,
   input  logic              addr_valid_i,
   output logic              addr_ready_o,
   input  logic [ADDR_W-1:0] addr_i,
   output logic              dout_valid_o,
   input  logic              dout_ready_i,
   output logic [DATA_W-1:0] dout_data_o
);

   import agu_pkg::*;

   typedef enum logic {
      OUT_EMPTY,
      OUT_FULL
   } out_state_e;

   out_state_e         state;
   logic [DATA_W-1:0]  mem [MEM_WORDS];
   logic [7:0]         raddr;
   logic               accept;

   assign raddr  = addr_i[BYTE_OFS_W +: 8];  // byte address to word index.

   // room when empty or when the held word leaves this cycle.
   assign addr_ready_o = (state == OUT_EMPTY) || dout_ready_i;
   assign accept       = addr_valid_i && addr_ready_o;
   assign dout_valid_o = (state == OUT_FULL);

   // ======================================================================
   // storage
   // ======================================================================
   always_ff @(posedge clk_i) begin
      if (we_i) begin
         mem[waddr_i] <= wdata_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (accept) begin
         dout_data_o <= mem[raddr];
      end
   end

   // ======================================================================
   // output register state
   // ======================================================================
   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         state <= OUT_EMPTY;
      end else begin
         case (state)
            OUT_EMPTY: if (accept) state <= OUT_FULL;
            OUT_FULL:  if (dout_ready_i && !accept) state <= OUT_EMPTY;
            default:   state <= OUT_EMPTY;
         endcase
      end
   end

endmodule

// File: logic/agu_addr_gen.sv
`timescale 1ns/10ps

module agu_addr_gen #(
   parameter int ADDR_W   = agu_pkg::ADDR_W,
   parameter int PERIOD_W = agu_pkg::PERIOD_W,
   parameter int DELAY_W  = agu_pkg::DELAY_W
) (
   input  logic              clk_i,
   input  logic              rst_i,
   agu_cfg_if.gen_mp         cfg,
   output logic              valid_o,
   input  logic              ready_i,
   output logic [ADDR_W-1:0] addr_o,
   output logic              done_o
);

   import agu_pkg::*;

   logic        [DELAY_W-1:0]  delay_cnt;
   logic        [ADDR_W-1:0]   iter;
   logic        [PERIOD_W-1:0] per;
   logic                       active;  // walking positions.
   logic                       in_duty;
   logic                       step;
   logic                       per_last;
   logic                       iter_last;
   logic signed [ADDR_W-1:0]   incr_ofs;
   logic signed [ADDR_W-1:0]   shift_ofs;

   // zero period or iteration count means a single pass.
   assign per_last  = (cfg.period == '0) || (per == cfg.period - 1'b1);
   assign iter_last = (cfg.iterations == '0) || (iter == cfg.iterations - 1'b1);

   assign incr_ofs  = cfg.incr <<< BYTE_OFS_W;   // words to bytes.
   assign shift_ofs = cfg.shift <<< BYTE_OFS_W;

   assign in_duty = per < cfg.duty;
   assign step    = active && ready_i;  // gap positions step too.
   assign valid_o = active && in_duty;

   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         delay_cnt <= '0;
         addr_o    <= '0;
         iter      <= '0;
         per       <= '0;
         active    <= 1'b0;
         done_o    <= 1'b1;
      end else if (cfg.run) begin
         delay_cnt <= cfg.delay;
         addr_o    <= cfg.start;
         iter      <= '0;
         per       <= '0;
         active    <= (cfg.delay == '0);
         done_o    <= 1'b0;
      end else if (delay_cnt != '0) begin
         delay_cnt <= delay_cnt - 1'b1;
         active    <= (delay_cnt == DELAY_W'(1));
      end else if (step) begin
         if (per_last) begin
            per <= '0;
            if (iter_last) begin
               iter   <= '0;
               active <= 1'b0;
               done_o <= 1'b1;  // last position taken.
            end else begin
               iter   <= iter + 1'b1;
               addr_o <= addr_o + shift_ofs;
            end
         end else begin
            per <= per + 1'b1;
            if (in_duty) begin
               addr_o <= addr_o + incr_ofs;
            end
         end
      end
   end

endmodule

// File: logic/agu_regs.sv
`timescale 1ns/10ps

module agu_regs #(
   parameter int ADDR_W   = agu_pkg::ADDR_W,
   parameter int PERIOD_W = agu_pkg::PERIOD_W,
   parameter int DELAY_W  = agu_pkg::DELAY_W,
   parameter int DATA_W   = agu_pkg::DATA_W
) (
   input  logic                         clk_i,
   input  logic                         rst_i,
   input  logic                         psel_i,
   input  logic                         penable_i,
   input  logic                         pwrite_i,
   input  logic [agu_pkg::PADDR_W-1:0]  paddr_i,
   input  logic [DATA_W-1:0]            pwdata_i,
   output logic [DATA_W-1:0]            prdata_o,
   output logic                         pready_o,
   output logic                         pslverr_o,
   agu_cfg_if.regs_mp                   cfg,
   input  logic                         done_i,
   output logic                         mem_we_o,
   output logic [7:0]                   mem_waddr_o,
   output logic [DATA_W-1:0]            mem_wdata_o
);

   import agu_pkg::*;

   agu_reg_e           reg_sel;
   logic               wr_en;
   logic               win_hit;
   logic [DATA_W-1:0]  ctrl_q;

   assign reg_sel = agu_reg_e'(paddr_i);
   assign wr_en   = psel_i && penable_i && pwrite_i;  // end of access phase.
   assign win_hit = (paddr_i >= MEM_BASE) &&
                    (paddr_i < MEM_BASE + PADDR_W'(MEM_WORDS << BYTE_OFS_W));

   assign pready_o  = 1'b1;
   assign pslverr_o = 1'b0;

   // ======================================================================
   // scratchpad write window
   // ======================================================================
   assign mem_we_o    = wr_en && win_hit;
   assign mem_waddr_o = paddr_i[BYTE_OFS_W +: 8];
   assign mem_wdata_o = pwdata_i;

   // ======================================================================
   // configuration registers
   // ======================================================================
   always_ff @(posedge clk_i or posedge rst_i) begin
      if (rst_i) begin
         ctrl_q         <= '0;
         cfg.run        <= 1'b0;
         cfg.start      <= '0;
         cfg.duty       <= '0;
         cfg.period     <= '0;
         cfg.incr       <= '0;
         cfg.iterations <= '0;
         cfg.shift      <= '0;
         cfg.delay      <= '0;
      end else begin
         cfg.run <= wr_en && (reg_sel == REG_CTRL) && pwdata_i[0] && done_i;
         if (wr_en) begin
            case (reg_sel)
               REG_CTRL:   if (done_i) ctrl_q <= pwdata_i;  // ignored while busy.
               REG_START:  cfg.start      <= pwdata_i[ADDR_W-1:0];
               REG_DUTY:   cfg.duty       <= pwdata_i[PERIOD_W-1:0];
               REG_PERIOD: cfg.period     <= pwdata_i[PERIOD_W-1:0];
               REG_INCR:   cfg.incr       <= pwdata_i[ADDR_W-1:0];
               REG_ITER:   cfg.iterations <= pwdata_i[ADDR_W-1:0];
               REG_SHIFT:  cfg.shift      <= pwdata_i[ADDR_W-1:0];
               REG_DELAY:  cfg.delay      <= pwdata_i[DELAY_W-1:0];
               default:    ;
            endcase
         end
      end
   end

   // read mux, window and unmapped offsets return zero.
   always_comb begin
      case (reg_sel)
         REG_CTRL:   prdata_o = ctrl_q;
         REG_START:  prdata_o = DATA_W'(cfg.start);
         REG_DUTY:   prdata_o = DATA_W'(cfg.duty);
         REG_PERIOD: prdata_o = DATA_W'(cfg.period);
         REG_INCR:   prdata_o = DATA_W'(cfg.incr);  // sign extended.
         REG_ITER:   prdata_o = DATA_W'(cfg.iterations);
         REG_SHIFT:  prdata_o = DATA_W'(cfg.shift);
         REG_DELAY:  prdata_o = DATA_W'(cfg.delay);
         REG_STATUS: prdata_o = DATA_W'(done_i);
         default:    prdata_o = '0;
      endcase
   end

endmodule

// File: logic/agu_cfg_if.sv
`timescale 1ns/10ps

interface agu_cfg_if #(
   parameter int ADDR_W   = agu_pkg::ADDR_W,
   parameter int PERIOD_W = agu_pkg::PERIOD_W,
   parameter int DELAY_W  = agu_pkg::DELAY_W
) ();

   logic                       run;  // single-cycle start pulse.
   logic        [ADDR_W-1:0]   start;
   logic        [PERIOD_W-1:0] duty;
   logic        [PERIOD_W-1:0] period;
   logic signed [ADDR_W-1:0]   incr;  // in words.
   logic        [ADDR_W-1:0]   iterations;
   logic signed [ADDR_W-1:0]   shift;  // in words.
   logic        [DELAY_W-1:0]  delay;

   modport regs_mp (
      output run, start, duty, period, incr, iterations, shift, delay
   );

   modport gen_mp (
      input run, start, duty, period, incr, iterations, shift, delay
   );

endinterface

// File: logic/agu_pkg.sv
package agu_pkg;

   // ======================================================================
   // widths
   // ======================================================================
   localparam int ADDR_W   = 10;  // byte address.
   localparam int PERIOD_W = 10;
   localparam int DELAY_W  = 7;
   localparam int DATA_W   = 32;
   localparam int PADDR_W  = 12;

   localparam int BYTE_OFS_W = 2;    // byte offset bits in a word.
   localparam int MEM_WORDS  = 256;

   // ======================================================================
   // register map
   // ======================================================================
   localparam logic [PADDR_W-1:0] MEM_BASE = 12'h400;  // scratchpad window.

   typedef enum logic [PADDR_W-1:0] {
      REG_CTRL   = 12'h000,
      REG_START  = 12'h004,
      REG_DUTY   = 12'h008,
      REG_PERIOD = 12'h00C,
      REG_INCR   = 12'h010,
      REG_ITER   = 12'h014,
      REG_SHIFT  = 12'h018,
      REG_DELAY  = 12'h01C,
      REG_STATUS = 12'h020
   } agu_reg_e;

endpackage
